/* tests/rs5_patterns.txt */
// Hex words. Per section: program word count, store count, program words,
// then one address and data pair per expected store, in store order
3
// ALU and immediates, 21 words, 10 stores
15 0a
00500093 ffd08113 123451b7 00208233
401102b3 0051f333 003263b3 0053c433
0012a4b3 0050a533 10102023 10202223
10302423 10402623 10502823 10602a23
10702c23 10802e23 12902023 12a02223
0000006f
00000100 00000005 00000104 00000002
00000108 12345000 0000010c 00000007
00000110 fffffffd 00000114 12345000
00000118 12345007 0000011c edcbaffa
00000120 00000001 00000124 00000000
// Load-use, 11 words, 4 stores, last load reads the memory fill at 0x300
0b 04
02a00093 20102023 20002103 00110193
20302223 20002203 004202b3 20502423
30002303 20602623 0000006f
00000200 0000002a 00000204 0000002b
00000208 00000054 0000020c fcff0300
// Control flow, 13 words, 3 stores, JAL link from 0x20 is 0x24
0d 03
00700093 00700113 00208663 40102623
40202823 40102023 00209463 40202223
00c002ef 40102a23 40102c23 40502423
0000006f
00000400 00000007 00000404 00000007
00000408 00000024

/* rs5.f */
+incdir+include
hw/rs5_pkg.sv
hw/fetch.sv
hw/regbank.sv
hw/decode.sv
hw/execute.sv
hw/retire.sv
hw/rs5.sv
tests/rs5_tb.sv

/* tests/rs5_tb.sv */
//////////////////////////////////////////////////////////////////////
// rs5 testbench
// Runs the pattern-file programs on the core with an instruction ROM
// and a registered data memory, and checks the store sequence
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rs5_params.svh"

module rs5_tb;

    localparam int PAT_WORDS = 256;
    localparam int ROM_WORDS = 64;
    localparam int RAM_WORDS = 1024;
    localparam int NUM_SECT  = 3;

    logic             clk;
    logic             rst_n_i;
    logic             stall_i;
    logic [31:0]      instruction_i;
    logic [`XLEN-1:0] mem_data_i;
    logic [`XLEN-1:0] instruction_address_o;
    logic             mem_operation_enable_o;
    logic [3:0]       mem_write_enable_o;
    logic [`XLEN-1:0] mem_address_o;
    logic [`XLEN-1:0] mem_data_o;

    // Raw pattern words and the section index built from them
    logic [31:0] pat [PAT_WORDS];
    int          sect_prog [NUM_SECT];
    int          sect_len  [NUM_SECT];
    int          sect_exp  [NUM_SECT];
    int          sect_nst  [NUM_SECT];

    // Memory models
    logic [31:0]      rom [ROM_WORDS];
    logic [`XLEN-1:0] ram [RAM_WORDS];

    // Run state
    int          test_no;
    int          exp_ptr;
    int          exp_left;
    int          test_errors;
    int          errors;
    int          checks;
    int          tests_failed;
    logic        stall_en;
    logic [15:0] lfsr;

    // Request seen mid-cycle and applied at the next rising edge
    logic             req_en;
    logic             req_wr;
    logic [`XLEN-1:0] req_addr;
    logic [`XLEN-1:0] req_wdata;
    logic             was_stalled;
    logic [`XLEN-1:0] stalled_addr;

    rs5 rs5_i (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .stall_i               (stall_i),
        .instruction_i         (instruction_i),
        .mem_data_i            (mem_data_i),
        .instruction_address_o (instruction_address_o),
        .mem_operation_enable_o(mem_operation_enable_o),
        .mem_write_enable_o    (mem_write_enable_o),
        .mem_address_o         (mem_address_o),
        .mem_data_o            (mem_data_o)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Combinational instruction memory
    assign instruction_i = rom[instruction_address_o[7:2]];

    ////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////
    // Galois form stepped once per stall bit
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] test %0d %s = %h, expected %h", test_no, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_store();
        checks++;
        assert (exp_left > 0) else begin
            $display("Test %0d: store to %h after the last expected one",
                     test_no, mem_address_o);
            test_errors++;
        end
        if (exp_left > 0) begin
            compare_word("mem_write_enable_o", {28'h0, mem_write_enable_o}, 32'hf);
            compare_word("mem_address_o", mem_address_o, pat[exp_ptr]);
            compare_word("mem_data_o", mem_data_o, pat[exp_ptr + 1]);
            exp_ptr  += 2;
            exp_left -= 1;
        end
    endtask

    // Section layout is word count, store count, words and address data pairs
    task automatic read_patterns();
        int ptr;
        $readmemh("tests/rs5_patterns.txt", pat);
        assert (pat[0] == NUM_SECT) else begin
            $display("Pattern file does not hold %0d test sections", NUM_SECT);
            errors++;
        end
        ptr = 1;
        for (int s = 0; s < NUM_SECT; s++) begin
            sect_len[s]  = pat[ptr];
            sect_nst[s]  = pat[ptr + 1];
            sect_prog[s] = ptr + 2;
            sect_exp[s]  = ptr + 2 + sect_len[s];
            ptr          = sect_exp[s] + 2 * sect_nst[s];
        end
    endtask

    task automatic load_memories(input int sect);
        logic [`XLEN-1:0] addr;
        for (int i = 0; i < ROM_WORDS; i++) begin
            // Past the program end the core sees plain NOPs
            rom[i] = (i < sect_len[sect]) ? pat[sect_prog[sect] + i] : 32'h0000_0013;
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            addr   = `XLEN'(i) << 2;
            ram[i] = {~addr[15:0], addr[15:0]};
        end
        exp_ptr  = sect_exp[sect];
        exp_left = sect_nst[sect];
    endtask

    task automatic reset_core();
        rst_n_i = 1'b0;
        repeat (2) next_cycle();
        rst_n_i = 1'b1;
    endtask

    task automatic finish_test(input string label);
        if (test_errors == 0) begin
            $display("Test %0d (%s): pass", test_no, label);
        end else begin
            $display("Test %0d (%s): %0d error(s)", test_no, label, test_errors);
            tests_failed++;
        end
        errors += test_errors;
    endtask

    ////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////
    // Reset state and a quiet data port until the first memory op
    task automatic reset_test();
        int first_mem;
        test_no     = 1;
        test_errors = 0;
        stall_en    = 1'b0;
        load_memories(0);
        first_mem = sect_len[0];
        for (int i = sect_len[0] - 1; i >= 0; i--) begin
            if (rom[i][6:0] == 7'h03 || rom[i][6:0] == 7'h23) first_mem = i;
        end
        reset_core();
        @(negedge clk);
        compare_word("instruction_address_o", instruction_address_o, `RESET_PC);
        // Word i reaches execute two cycles after its fetch
        repeat (first_mem + 2) begin
            compare_word("mem_operation_enable_o", {31'h0, mem_operation_enable_o}, 32'h0);
            @(negedge clk);
        end
        checks++;
        assert (mem_operation_enable_o) else begin
            $display("Test 1: no memory access when the first one reached execute");
            test_errors++;
        end
        // Let the first store complete before the core is reset again
        next_cycle();
        finish_test("reset state");
    endtask

    task automatic run_program(input int sect, input int num, input logic stall_on,
                               input string label);
        test_no     = num;
        test_errors = 0;
        stall_en    = 1'b0;
        load_memories(sect);
        reset_core();
        stall_en = stall_on;
        wait (exp_left == 0);
        // Program now spins on its final JAL and must store nothing more
        stall_en = 1'b0;
        repeat (10) next_cycle();
        finish_test(label);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Memory model and port monitors
    ////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (stall_en) begin
            stall_i <= #1 lfsr[0];
            lfsr     = lfsr_next(lfsr);
        end else begin
            stall_i <= #1 1'b0;
        end
    end

    // Synchronous memory with read data one cycle after the request
    always @(posedge clk) begin
        if (req_en && req_wr) begin
            ram[req_addr[11:2]] = req_wdata;
        end else if (req_en) begin
            mem_data_i <= #1 ram[req_addr[11:2]];
        end
    end

    always @(negedge clk) begin
        req_en    = mem_operation_enable_o;
        req_wr    = mem_write_enable_o != 4'h0;
        req_addr  = mem_address_o;
        req_wdata = mem_data_o;
        if (!rst_n_i) begin
            was_stalled = 1'b0;
        end else begin
            if (req_en && req_wr) check_store();
            // Frozen fetch address across a stalled cycle
            if (was_stalled) begin
                compare_word("instruction_address_o", instruction_address_o, stalled_addr);
            end
            if (stall_i) begin
                compare_word("mem_operation_enable_o", {31'h0, mem_operation_enable_o}, 32'h0);
            end
            was_stalled  = stall_i;
            stalled_addr = instruction_address_o;
        end
    end

    initial begin
        int limit;
        rst_n_i      = 1'b0;
        stall_i      = 1'b0;
        mem_data_i   = '0;
        stall_en     = 1'b0;
        lfsr         = 16'd85;
        req_en       = 1'b0;
        was_stalled  = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_failed = 0;
        test_no      = 0;
        read_patterns();
        load_memories(0);
        // 50 cycles per word with double for the stalled rerun of test 2
        limit = 50 * (2 * sect_len[0] + sect_len[1] + sect_len[2]) + 100 * sect_len[0];
        fork
            begin
                reset_test();
                run_program(0, 2, 1'b0, "ALU and immediates");
                run_program(1, 3, 1'b0, "load-use");
                run_program(2, 4, 1'b0, "control flow");
                run_program(0, 5, 1'b1, "random stall");
            end
            begin
                repeat (limit) @(posedge clk);
                $display("Timeout: test %0d hung, %0d cycles elapsed", test_no, limit);
                $display("CHECKS FAILED");
                $finish;
            end
        join_any
        disable fork;
        $display("Summary: 5 tests, %0d failing, %0d checks, %0d errors",
                 tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/rs5.sv */
//////////////////////////////////////////////////////////////////////
// rs5 core top level
// Four-stage RV32I subset pipeline with instruction and data ports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rs5_params.svh"

module rs5 (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 stall_i,
    input  logic [31:0]          instruction_i,
    input  logic [`XLEN-1:0]     mem_data_i,
    output logic [`XLEN-1:0]     instruction_address_o,
    output logic                 mem_operation_enable_o,
    output logic [3:0]           mem_write_enable_o,
    output logic [`XLEN-1:0]     mem_address_o,
    output logic [`XLEN-1:0]     mem_data_o
);

    ////////////////////////////////////////////////////////////////////
    // Stage records and control
    ////////////////////////////////////////////////////////////////////
    rs5_pkg::if_id_t    if_id;
    rs5_pkg::id_ex_t    id_ex;
    rs5_pkg::ex_ret_t   ex_ret;
    rs5_pkg::dmem_req_t dmem_req;

    logic               jump;
    logic [`XLEN-1:0]   jump_target;
    logic               hazard;

    // Register bank ports
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`XLEN-1:0]   rdata1;
    logic [`XLEN-1:0]   rdata2;

    // Forwarding from execute
    logic               ex_fwd_valid;
    logic               ex_fwd_load;
    logic [`REG_AW-1:0] ex_fwd_rd;
    logic [`XLEN-1:0]   ex_fwd_data;

    // Writeback, also forwarded to decode
    logic               ret_we;
    logic [`REG_AW-1:0] ret_rd;
    logic [`XLEN-1:0]   ret_data;

    fetch fetch_i (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .stall_i              (stall_i),
        .hazard_i             (hazard),
        .jump_i               (jump),
        .jump_target_i        (jump_target),
        .instruction_i        (instruction_i),
        .instruction_address_o(instruction_address_o),
        .if_id_o              (if_id)
    );

    decode decode_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .jump_i        (jump),
        .if_id_i       (if_id),
        .rdata1_i      (rdata1),
        .rdata2_i      (rdata2),
        .ex_fwd_valid_i(ex_fwd_valid),
        .ex_fwd_load_i (ex_fwd_load),
        .ex_fwd_rd_i   (ex_fwd_rd),
        .ex_fwd_data_i (ex_fwd_data),
        .ret_we_i      (ret_we),
        .ret_rd_i      (ret_rd),
        .ret_data_i    (ret_data),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .hazard_o      (hazard),
        .id_ex_o       (id_ex)
    );

    regbank regbank_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .rd_i    (ret_rd),
        .we_i    (ret_we),
        .wdata_i (ret_data),
        .rdata1_o(rdata1),
        .rdata2_o(rdata2)
    );

    execute execute_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .id_ex_i      (id_ex),
        .jump_o       (jump),
        .jump_target_o(jump_target),
        .fwd_valid_o  (ex_fwd_valid),
        .fwd_load_o   (ex_fwd_load),
        .fwd_rd_o     (ex_fwd_rd),
        .fwd_data_o   (ex_fwd_data),
        .dmem_req_o   (dmem_req),
        .ex_ret_o     (ex_ret)
    );

    retire retire_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .stall_i   (stall_i),
        .ex_ret_i  (ex_ret),
        .mem_data_i(mem_data_i),
        .we_o      (ret_we),
        .rd_o      (ret_rd),
        .wdata_o   (ret_data)
    );

    ////////////////////////////////////////////////////////////////////
    // Data memory port
    ////////////////////////////////////////////////////////////////////
    // No access while frozen, it is issued once the stall lifts
    assign mem_operation_enable_o = (dmem_req.re || dmem_req.we != '0) && !stall_i;
    assign mem_write_enable_o     = dmem_req.we;
    assign mem_address_o          = dmem_req.addr;
    assign mem_data_o             = dmem_req.wdata;

endmodule

`default_nettype wire

/* hw/retire.sv */
//////////////////////////////////////////////////////////////////////
// rs5 retire stage
// Writeback select and register bank write port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rs5_params.svh"

module retire (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 stall_i,
    input  rs5_pkg::ex_ret_t     ex_ret_i,
    input  logic [`XLEN-1:0]     mem_data_i,
    output logic                 we_o,
    output logic [`REG_AW-1:0]   rd_o,
    output logic [`XLEN-1:0]     wdata_o
);

    // Held off while stalled so a frozen instruction writes once
    assign we_o    = ex_ret_i.valid && ex_ret_i.we && !stall_i;
    assign rd_o    = ex_ret_i.rd;
    // Synchronous memory, load data lands here
    assign wdata_o = ex_ret_i.load ? mem_data_i : ex_ret_i.result;

    // Decode never flags a write to x0
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        we_o |-> rd_o != '0);

endmodule

`default_nettype wire

/* hw/execute.sv */
//////////////////////////////////////////////////////////////////////
// rs5 execute stage
// ALU, branch and jump resolution, data memory request and the
// execute-to-retire register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rs5_params.svh"

module execute (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 stall_i,
    input  rs5_pkg::id_ex_t      id_ex_i,
    output logic                 jump_o,
    output logic [`XLEN-1:0]     jump_target_o,
    output logic                 fwd_valid_o,
    output logic                 fwd_load_o,
    output logic [`REG_AW-1:0]   fwd_rd_o,
    output logic [`XLEN-1:0]     fwd_data_o,
    output rs5_pkg::dmem_req_t   dmem_req_o,
    output rs5_pkg::ex_ret_t     ex_ret_o
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] addr_sum;
    logic [`XLEN-1:0] result;
    logic             taken;
    logic             is_load;
    logic             is_store;
    rs5_pkg::ex_ret_t ex_ret_q;

    assign op_a     = id_ex_i.rs1_data;
    assign op_b     = id_ex_i.rs2_data;
    // Shared by ADDI, loads and stores
    assign addr_sum = op_a + id_ex_i.imm;
    assign is_load  = id_ex_i.valid && id_ex_i.op == rs5_pkg::OP_LW;
    assign is_store = id_ex_i.valid && id_ex_i.op == rs5_pkg::OP_SW;

    ////////////////////////////////////////////////////////////////////
    // ALU and branch compare
    ////////////////////////////////////////////////////////////////////
    always_comb begin : alu
        result = '0;
        taken  = 1'b0;
        case (id_ex_i.op)
            rs5_pkg::OP_ADD:  result = op_a + op_b;
            rs5_pkg::OP_SUB:  result = op_a - op_b;
            rs5_pkg::OP_AND:  result = op_a & op_b;
            rs5_pkg::OP_OR:   result = op_a | op_b;
            rs5_pkg::OP_XOR:  result = op_a ^ op_b;
            rs5_pkg::OP_SLT:  result = `XLEN'($signed(op_a) < $signed(op_b));
            rs5_pkg::OP_ADDI,
            rs5_pkg::OP_LW,
            rs5_pkg::OP_SW:   result = addr_sum;
            rs5_pkg::OP_LUI:  result = id_ex_i.imm;
            rs5_pkg::OP_JAL: begin
                // Link value
                result = id_ex_i.pc + `XLEN'(4);
                taken  = 1'b1;
            end
            rs5_pkg::OP_BEQ:  taken = op_a == op_b;
            rs5_pkg::OP_BNE:  taken = op_a != op_b;
            default:          result = '0;
        endcase
    end

    // Branches and JAL share the PC-relative target
    assign jump_o        = id_ex_i.valid && taken;
    assign jump_target_o = id_ex_i.pc + id_ex_i.imm;

    // Forwarding view of the instruction in flight
    assign fwd_valid_o = id_ex_i.valid && id_ex_i.we;
    assign fwd_load_o  = is_load;
    assign fwd_rd_o    = id_ex_i.rd;
    assign fwd_data_o  = result;

    // Word access only, byte enables all set or all clear
    assign dmem_req_o = '{re:    is_load,
                          we:    {4{is_store}},
                          addr:  addr_sum,
                          wdata: op_b};

    ////////////////////////////////////////////////////////////////////
    // Execute to retire register
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_ret_q <= '0;
        end else if (!stall_i) begin
            ex_ret_q <= '{valid:  id_ex_i.valid,
                          load:   is_load,
                          we:     id_ex_i.we,
                          rd:     id_ex_i.rd,
                          result: result};
        end
    end

    assign ex_ret_o = ex_ret_q;

    a_rw_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(dmem_req_o.re && dmem_req_o.we != '0));

    // Decode must flush behind a taken jump
    a_jump_flush: assert property (@(posedge clk) disable iff (!rst_n_i)
        jump_o && !stall_i |=> !id_ex_i.valid);

endmodule

`default_nettype wire

/* hw/decode.sv */
//////////////////////////////////////////////////////////////////////
// rs5 decode stage
// Instruction decode, immediates, operand forwarding, load-use
// hazard and the decode-to-execute register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rs5_params.svh"

module decode (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 stall_i,
    input  logic                 jump_i,
    input  rs5_pkg::if_id_t      if_id_i,
    input  logic [`XLEN-1:0]     rdata1_i,
    input  logic [`XLEN-1:0]     rdata2_i,
    input  logic                 ex_fwd_valid_i,
    input  logic                 ex_fwd_load_i,
    input  logic [`REG_AW-1:0]   ex_fwd_rd_i,
    input  logic [`XLEN-1:0]     ex_fwd_data_i,
    input  logic                 ret_we_i,
    input  logic [`REG_AW-1:0]   ret_rd_i,
    input  logic [`XLEN-1:0]     ret_data_i,
    output logic [`REG_AW-1:0]   rs1_o,
    output logic [`REG_AW-1:0]   rs2_o,
    output logic                 hazard_o,
    output rs5_pkg::id_ex_t      id_ex_o
);

    logic [31:0]        instr;
    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [`REG_AW-1:0] rd;
    rs5_pkg::op_e       op;
    logic [`XLEN-1:0]   imm;
    logic               use_rs1;
    logic               use_rs2;
    logic               writes_rd;
    rs5_pkg::id_ex_t    id_ex_q;

    // Youngest producer wins: execute, then retire, then the bank
    function automatic logic [`XLEN-1:0] fwd_sel(input logic [`REG_AW-1:0] rs,
                                                 input logic [`XLEN-1:0]   bank);
        if (ex_fwd_valid_i && !ex_fwd_load_i && ex_fwd_rd_i == rs) begin
            return ex_fwd_data_i;
        end
        if (ret_we_i && ret_rd_i == rs) begin
            return ret_data_i;
        end
        return bank;
    endfunction

    assign instr  = if_id_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1_o  = instr[19:15];
    assign rs2_o  = instr[24:20];

    ////////////////////////////////////////////////////////////////////
    // Opcode mapping
    ////////////////////////////////////////////////////////////////////
    always_comb begin : op_map
        op = rs5_pkg::OP_NOP;
        case (opcode)
            7'b0110011: begin
                if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    op = rs5_pkg::OP_SUB;
                end else if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  op = rs5_pkg::OP_ADD;
                        3'b010:  op = rs5_pkg::OP_SLT;
                        3'b100:  op = rs5_pkg::OP_XOR;
                        3'b110:  op = rs5_pkg::OP_OR;
                        3'b111:  op = rs5_pkg::OP_AND;
                        default: op = rs5_pkg::OP_NOP;
                    endcase
                end
            end
            7'b0010011: if (funct3 == 3'b000) op = rs5_pkg::OP_ADDI;
            7'b0110111: op = rs5_pkg::OP_LUI;
            7'b0000011: if (funct3 == 3'b010) op = rs5_pkg::OP_LW;
            7'b0100011: if (funct3 == 3'b010) op = rs5_pkg::OP_SW;
            7'b1100011: begin
                if (funct3 == 3'b000) op = rs5_pkg::OP_BEQ;
                if (funct3 == 3'b001) op = rs5_pkg::OP_BNE;
            end
            7'b1101111: op = rs5_pkg::OP_JAL;
            // Anything else falls through as a no-op
            default: op = rs5_pkg::OP_NOP;
        endcase
    end

    // Immediate format per operation
    always_comb begin : imm_gen
        case (op)
            rs5_pkg::OP_ADDI,
            rs5_pkg::OP_LW:  imm = {{20{instr[31]}}, instr[31:20]};
            rs5_pkg::OP_SW:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rs5_pkg::OP_BEQ,
            rs5_pkg::OP_BNE: imm = {{19{instr[31]}}, instr[31], instr[7],
                                    instr[30:25], instr[11:8], 1'b0};
            rs5_pkg::OP_LUI: imm = {instr[31:12], 12'b0};
            rs5_pkg::OP_JAL: imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                    instr[20], instr[30:21], 1'b0};
            default:         imm = '0;
        endcase
    end

    // Register usage
    assign use_rs1   = !(op inside {rs5_pkg::OP_NOP, rs5_pkg::OP_LUI, rs5_pkg::OP_JAL});
    assign use_rs2   = op inside {rs5_pkg::OP_ADD, rs5_pkg::OP_SUB, rs5_pkg::OP_AND,
                                  rs5_pkg::OP_OR, rs5_pkg::OP_XOR, rs5_pkg::OP_SLT,
                                  rs5_pkg::OP_SW, rs5_pkg::OP_BEQ, rs5_pkg::OP_BNE};
    assign writes_rd = !(op inside {rs5_pkg::OP_NOP, rs5_pkg::OP_SW,
                                    rs5_pkg::OP_BEQ, rs5_pkg::OP_BNE});

    ////////////////////////////////////////////////////////////////////
    // Load-use hazard
    ////////////////////////////////////////////////////////////////////
    // Load value only exists in retire, so a dependent waits one cycle
    assign hazard_o = if_id_i.valid && ex_fwd_valid_i && ex_fwd_load_i &&
                      ((use_rs1 && ex_fwd_rd_i == rs1_o) ||
                       (use_rs2 && ex_fwd_rd_i == rs2_o));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q <= '0;
        end else if (!stall_i) begin
            // Flush on a taken jump, bubble on a hazard
            id_ex_q.valid    <= if_id_i.valid && !jump_i && !hazard_o;
            id_ex_q.op       <= op;
            id_ex_q.rd       <= rd;
            id_ex_q.we       <= writes_rd && rd != '0;
            id_ex_q.rs1_data <= fwd_sel(rs1_o, rdata1_i);
            id_ex_q.rs2_data <= fwd_sel(rs2_o, rdata2_i);
            id_ex_q.imm      <= imm;
            id_ex_q.pc       <= if_id_i.pc;
        end
    end

    assign id_ex_o = id_ex_q;

    // Hazard needs a load in execute, and the bubble clears it next cycle
    a_hazard_src: assert property (@(posedge clk) disable iff (!rst_n_i)
        hazard_o |-> ex_fwd_valid_i && ex_fwd_load_i);
    a_hazard_one: assert property (@(posedge clk) disable iff (!rst_n_i)
        hazard_o && !stall_i |=> !hazard_o);

endmodule

`default_nettype wire

/* hw/regbank.sv */
//////////////////////////////////////////////////////////////////////
// rs5 register bank
// Flip-flop array, two asynchronous reads, one write, x0 tied to zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rs5_params.svh"

module regbank (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [`REG_AW-1:0]   rs1_i,
    input  logic [`REG_AW-1:0]   rs2_i,
    input  logic [`REG_AW-1:0]   rd_i,
    input  logic                 we_i,
    input  logic [`XLEN-1:0]     wdata_i,
    output logic [`XLEN-1:0]     rdata1_o,
    output logic [`XLEN-1:0]     rdata2_o
);

    logic [`XLEN-1:0] regs_q [`NUM_REGS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            // x0 is never written
            regs_q[rd_i] <= wdata_i;
        end
    end

    assign rdata1_o = regs_q[rs1_i];
    assign rdata2_o = regs_q[rs2_i];

endmodule

`default_nettype wire

/* hw/fetch.sv */
//////////////////////////////////////////////////////////////////////
// rs5 fetch stage
// Program counter and the fetch-to-decode register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rs5_params.svh"

module fetch (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 stall_i,
    input  logic                 hazard_i,
    input  logic                 jump_i,
    input  logic [`XLEN-1:0]     jump_target_i,
    input  logic [31:0]          instruction_i,
    output logic [`XLEN-1:0]     instruction_address_o,
    output rs5_pkg::if_id_t      if_id_o
);

    logic [`XLEN-1:0] pc_q;
    rs5_pkg::if_id_t  if_id_q;

    // Memory answers in the same cycle, so the PC is the fetch address
    assign instruction_address_o = pc_q;
    assign if_id_o               = if_id_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q    <= `RESET_PC;
            if_id_q <= '0;
        end else if (!stall_i) begin
            if (jump_i) begin
                // Redirect, word in flight is dropped
                pc_q          <= jump_target_i;
                if_id_q.valid <= 1'b0;
            end else if (!hazard_i) begin
                pc_q    <= pc_q + `XLEN'(4);
                if_id_q <= '{valid: 1'b1, instr: instruction_i, pc: pc_q};
            end
            // Hazard holds both PC and the decode word
        end
    end

    // Jump targets come from execute and must keep word alignment
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        instruction_address_o[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hw/rs5_pkg.sv */
//////////////////////////////////////////////////////////////////////
// rs5 shared types
// Operation encoding and the stage-to-stage pipeline records
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "rs5_params.svh"

package rs5_pkg;

    // Supported operations, zero is the no-op so a cleared record is a bubble
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_SLT  = 4'd6,
        OP_ADDI = 4'd7,
        OP_LUI  = 4'd8,
        OP_LW   = 4'd9,
        OP_SW   = 4'd10,
        OP_BEQ  = 4'd11,
        OP_BNE  = 4'd12,
        OP_JAL  = 4'd13
    } op_e;

    // Fetch to decode
    typedef struct packed {
        logic             valid;
        logic [31:0]      instr;
        logic [`XLEN-1:0] pc;
    } if_id_t;

    // Decode to execute, operands already forwarded
    typedef struct packed {
        logic               valid;
        op_e                op;
        logic [`REG_AW-1:0] rd;
        logic               we;
        logic [`XLEN-1:0]   rs1_data;
        logic [`XLEN-1:0]   rs2_data;
        logic [`XLEN-1:0]   imm;
        logic [`XLEN-1:0]   pc;
    } id_ex_t;

    // Execute to retire
    typedef struct packed {
        logic               valid;
        logic               load;
        logic               we;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   result;
    } ex_ret_t;

    // Data memory request, word stores only
    typedef struct packed {
        logic             re;
        logic [3:0]       we;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } dmem_req_t;

endpackage

`default_nettype wire

/* include/rs5_params.svh */
//////////////////////////////////////////////////////////////////////
// rs5 core parameters
// Data width, register file geometry and the first fetch address
//////////////////////////////////////////////////////////////////////

`ifndef RS5_PARAMS_SVH
`define RS5_PARAMS_SVH

// Data and address width
`define XLEN 32

// Architectural register file
`define NUM_REGS 32
`define REG_AW 5

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif
